// File: logic/clock_pkg.sv
//--------------------
// clock package
// digit, segment and select types for the MM:SS display,
// plus the BCD to seven-segment encoding
//--------------------
`default_nettype none

package clock_pkg;

    localparam int NUM_DIGITS = 4;              // two seconds + two minutes digits

    typedef logic [3:0] digit_t;                // one BCD digit
    typedef logic [6:0] seg_t;                  // bit 0 = seg A, bit 6 = seg G, active low
    typedef logic [1:0] digit_sel_t;            // 0 = sec units .. 3 = min tens

    localparam seg_t SEG_ZERO = 7'h40;          // only G dark

    // Segments are active low, so a cleared bit lights that segment.
    function automatic seg_t encode_digit(input digit_t value);
        seg_t pattern;
        case (value)
            4'd0:    pattern = SEG_ZERO;
            4'd1:    pattern = 7'h79;           // B, C
            4'd2:    pattern = 7'h24;
            4'd3:    pattern = 7'h30;
            4'd4:    pattern = 7'h19;
            4'd5:    pattern = 7'h12;
            4'd6:    pattern = 7'h02;
            4'd7:    pattern = 7'h78;           // A, B, C
            4'd8:    pattern = 7'h00;           // all lit
            4'd9:    pattern = 7'h18;
            default: pattern = SEG_ZERO;        // non-BCD shows zero
        endcase
        return pattern;
    endfunction

endpackage

`default_nettype wire

// File: logic/tick_divider.sv
//--------------------
// tick divider
// free-running cycle counter, one-cycle tick every PERIOD clocks
//--------------------
`timescale 1ns/1ps
`default_nettype none

module tick_divider #(
    parameter int PERIOD = 27_000_000
) (
    input  logic sys_clk,
    input  logic sys_rst_n,
    output logic tick
);

    localparam int CNT_W = (PERIOD > 1) ? $clog2(PERIOD) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(PERIOD - 1);

    logic [CNT_W-1:0] cnt;                      // cycles since last tick

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            cnt <= '0;
        end
        else if (cnt == LAST)
        begin
            cnt <= '0;                          // wrap with the tick
        end
        else
        begin
            cnt <= cnt + 1'b1;
        end
    end

    assign tick = (cnt == LAST);                // high in the PERIOD-th cycle

    // counter must never run past the wrap point
    a_cnt_range: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        cnt <= LAST
    ) else $error("tick_divider count %0d past %0d", cnt, LAST);

endmodule

`default_nettype wire

// File: logic/sexagesimal_counter.sv
//--------------------
// modulo-60 BCD counter
// two digits 00..59, advancing on tick, carry at the 59 -> 00 wrap
//--------------------
`timescale 1ns/1ps
`default_nettype none

module sexagesimal_counter
    import clock_pkg::*;
(
    input  logic   sys_clk,
    input  logic   sys_rst_n,
    input  logic   tick,
    output digit_t units,
    output digit_t tens,
    output logic   carry
);

    logic units_max;                            // units at 9
    logic tens_max;                             // tens at 5

    assign units_max = (units == 4'd9);
    assign tens_max  = (tens == 4'd5);

    // wrap marker in the same cycle as the tick that takes 59 to 00
    assign carry = tick && units_max && tens_max;

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            units <= 4'd0;
            tens  <= 4'd0;
        end
        else if (tick)
        begin
            if (units_max)
            begin
                units <= 4'd0;
                if (tens_max)
                begin
                    tens <= 4'd0;               // 59 -> 00
                end
                else
                begin
                    tens <= tens + 4'd1;
                end
            end
            else
            begin
                units <= units + 4'd1;
            end
        end
    end

    a_units_bcd: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        units <= 4'd9
    ) else $error("units digit %0d out of range", units);

    a_tens_range: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        tens <= 4'd5
    ) else $error("tens digit %0d out of range", tens);

endmodule

`default_nettype wire

// File: logic/digit_scan.sv
//--------------------
// digit scan
// rotates the digit select, encodes the four digits and drives
// the active-low segments and the one-hot digit enable
//--------------------
`timescale 1ns/1ps
`default_nettype none

module digit_scan
    import clock_pkg::*;
(
    input  logic                  sys_clk,
    input  logic                  sys_rst_n,
    input  logic                  scan_tick,
    input  digit_t                sec_units,
    input  digit_t                sec_tens,
    input  digit_t                min_units,
    input  digit_t                min_tens,
    output seg_t                  seg,
    output logic [NUM_DIGITS-1:0] digit_en
);

    digit_sel_t sel;                            // digit being driven
    digit_t     digits [NUM_DIGITS];            // indexed by display position
    seg_t       pat_q  [NUM_DIGITS];            // stage 1, encoded patterns

    assign digits[0] = sec_units;
    assign digits[1] = sec_tens;
    assign digits[2] = min_units;
    assign digits[3] = min_tens;

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            sel <= '0;
        end
        else if (scan_tick)
        begin
            sel <= sel + digit_sel_t'(1);       // wraps 3 -> 0
        end
    end

    // stage 1 encodes every digit each cycle
    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            for (int i = 0; i < NUM_DIGITS; i++)
            begin
                pat_q[i] <= SEG_ZERO;
            end
        end
        else
        begin
            for (int i = 0; i < NUM_DIGITS; i++)
            begin
                pat_q[i] <= encode_digit(digits[i]);
            end
        end
    end

    // stage 2 picks the selected pattern and lights its digit
    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            seg      <= SEG_ZERO;
            digit_en <= '1;                     // all digits on in reset
        end
        else
        begin
            seg      <= pat_q[sel];
            digit_en <= NUM_DIGITS'(1) << sel;
        end
    end

endmodule

`default_nettype wire

// File: logic/clock_display_top.sv
//--------------------
// MM:SS seven-segment clock
// seconds and scan dividers, seconds and minutes counters,
// and the multiplexed display scan
//--------------------
`timescale 1ns/1ps
`default_nettype none

module clock_display_top
    import clock_pkg::*;
#(
    parameter int SEC_PERIOD  = 27_000_000,     // cycles per second
    parameter int SCAN_PERIOD = 27_000          // cycles per digit step
) (
    input  logic                  sys_clk,
    input  logic                  sys_rst_n,
    output seg_t                  seg,
    output logic [NUM_DIGITS-1:0] digit_en
);

    logic   sec_tick;                           // once per second
    logic   scan_tick;                          // once per digit step
    logic   sec_carry;                          // seconds 59 -> 00
    digit_t sec_units;
    digit_t sec_tens;
    digit_t min_units;
    digit_t min_tens;

    tick_divider #(
        .PERIOD    (SEC_PERIOD)
    ) u_sec_divider (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .tick      (sec_tick)
    );

    tick_divider #(
        .PERIOD    (SCAN_PERIOD)
    ) u_scan_divider (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .tick      (scan_tick)
    );

    sexagesimal_counter u_sec_counter (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .tick      (sec_tick),
        .units     (sec_units),
        .tens      (sec_tens),
        .carry     (sec_carry)
    );

    // minutes advance on the same edge as the seconds wrap
    sexagesimal_counter u_min_counter (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .tick      (sec_carry),
        .units     (min_units),
        .tens      (min_tens),
        .carry     ()                           // no hours digit
    );

    digit_scan u_digit_scan (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .scan_tick (scan_tick),
        .sec_units (sec_units),
        .sec_tens  (sec_tens),
        .min_units (min_units),
        .min_tens  (min_tens),
        .seg       (seg),
        .digit_en  (digit_en)
    );

endmodule

`default_nettype wire

// File: verif/clock_display_tb.sv
//--------------------
// clock display testbench
// runs the MM:SS clock past the 59:59 wrap and a mid-run reset,
// checking seg and digit_en against a cycle model on every edge
//--------------------
`timescale 1ns/1ps
`default_nettype none

module clock_display_tb
    import clock_pkg::*;
();

    localparam int SEC_PERIOD   = 2;
    localparam int SCAN_PERIOD  = 3;
    localparam int CLK_HALF     = 50;           // 100 ns clock period
    localparam int DRIVE_DELAY  = 5;            // inputs change after the edge
    localparam int SAMPLE_DELAY = 2;            // outputs settled by then
    localparam int RESET_CYCLES = 8;
    localparam int WRAP_SECONDS = 3600;         // one full MM:SS cycle

    logic                  sys_clk;
    logic                  sys_rst_n;
    seg_t                  seg;
    logic [NUM_DIGITS-1:0] digit_en;

    int                    error_count   = 0;
    int                    check_count   = 0;
    int                    edge_count    = 0;   // edges since reset release
    int                    prev_secs     = 0;
    int                    seed;
    bit                    saw_full_wrap = 1'b0;
    logic [NUM_DIGITS-1:0] en_seen       = '0;  // digit positions lit so far

    clock_display_top #(
        .SEC_PERIOD  (SEC_PERIOD),
        .SCAN_PERIOD (SCAN_PERIOD)
    ) u_clock_display_top (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .seg         (seg),
        .digit_en    (digit_en)
    );

    initial
    begin
        sys_clk = 1'b0;
        forever
        begin
            #CLK_HALF sys_clk = ~sys_clk;
        end
    end

    // active low with bit 0 as A up to bit 6 as G
    function automatic seg_t seg_pattern(input int value);
        seg_t pattern;
        case (value)
            0:       pattern = 7'b1000000;
            1:       pattern = 7'b1111001;
            2:       pattern = 7'b0100100;
            3:       pattern = 7'b0110000;
            4:       pattern = 7'b0011001;
            5:       pattern = 7'b0010010;
            6:       pattern = 7'b0000010;
            7:       pattern = 7'b1111000;
            8:       pattern = 7'b0000000;
            9:       pattern = 7'b0011000;
            default: pattern = 7'b1000000;
        endcase
        return pattern;
    endfunction

    // displayed time lags the counters by two edges
    function automatic int model_seconds(input int n);
        int t;
        t = (n >= 2) ? n - 2 : 0;
        return (t / SEC_PERIOD) % WRAP_SECONDS;
    endfunction

    // expected outputs after edge n since reset release (0 while in reset)
    function automatic void model_display(input int n, output seg_t seg_exp,
                                          output logic [NUM_DIGITS-1:0] en_exp);
        int sel;
        int secs;
        int digit;
        if (n <= 0)
        begin
            seg_exp = seg_pattern(0);
            en_exp  = '1;
        end
        else
        begin
            sel  = ((n - 1) / SCAN_PERIOD) % NUM_DIGITS;
            secs = model_seconds(n);
            case (sel)
                0:       digit = secs % 10;         // seconds units
                1:       digit = (secs % 60) / 10;  // seconds tens
                2:       digit = (secs / 60) % 10;  // minutes units
                default: digit = secs / 600;        // minutes tens
            endcase
            seg_exp = seg_pattern(digit);
            en_exp  = '0;
            en_exp[sel[1:0]] = 1'b1;                // only the scanned digit lit
        end
    endfunction

    task automatic report_and_finish;
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    endtask

    // leaves the caller at the drive point of the last edge
    task automatic wait_cycles(input int count);
        int i;
        for (i = 0; i < count; i++)
        begin
            @(posedge sys_clk);
        end
        #DRIVE_DELAY;
    endtask

    task automatic wait_for_outputs(input seg_t seg_want,
                                    input logic [NUM_DIGITS-1:0] en_want,
                                    input int max_cycles, input string what);
        int waited;
        waited = 0;
        #1;                                     // let an async reset settle
        while ((seg !== seg_want || digit_en !== en_want) && waited < max_cycles)
        begin
            @(posedge sys_clk);
            #SAMPLE_DELAY;
            waited = waited + 1;
        end
        if (seg !== seg_want || digit_en !== en_want)
        begin
            error_count = error_count + 1;
            $display("timed out after %0d cycles waiting for %s", max_cycles, what);
        end
        @(posedge sys_clk);
        #DRIVE_DELAY;                           // back on the drive grid
    endtask

    initial
    begin : compare_outputs
        seg_t                  seg_exp;
        logic [NUM_DIGITS-1:0] en_exp;
        int                    secs;
        forever
        begin
            @(posedge sys_clk);
            #SAMPLE_DELAY;
            if (!sys_rst_n)
            begin
                edge_count = 0;                 // model restarts at 00:00
                prev_secs  = 0;
            end
            else
            begin
                edge_count = edge_count + 1;
            end
            model_display(edge_count, seg_exp, en_exp);
            check_count = check_count + 1;
            if (seg !== seg_exp)
            begin
                error_count = error_count + 1;
                $display("[FAIL] time %0d ns: seg expected %b, got %b",
                         $time, seg_exp, seg);
            end
            if (digit_en !== en_exp)
            begin
                error_count = error_count + 1;
                $display("[FAIL] time %0d ns: digit_en expected %b, got %b",
                         $time, en_exp, digit_en);
            end
            if (sys_rst_n)
            begin
                secs = model_seconds(edge_count);
                if (prev_secs == WRAP_SECONDS - 1 && secs == 0)
                begin
                    saw_full_wrap = 1'b1;       // 59:59 -> 00:00 shown
                end
                prev_secs = secs;
                en_seen   = en_seen | digit_en;
            end
        end
    end

    initial
    begin : drive_stimulus
        int rand_val;
        int first_run;
        sys_rst_n = 1'b0;
        seed      = 32'ha53ec2cd;
        wait_cycles(RESET_CYCLES);
        sys_rst_n = 1'b1;
        wait_for_outputs(seg_pattern(0), 4'b0001, 4, "the first digit enable after reset");

        // long enough to pass the full hour wrap plus a random tail
        rand_val  = $random(seed);
        first_run = SEC_PERIOD * WRAP_SECONDS + 100 + ((rand_val & 32'h7fff_ffff) % 200);
        wait_cycles(first_run);

        // mid-run reset
        sys_rst_n = 1'b0;
        wait_for_outputs(seg_pattern(0), '1, 2, "the outputs to return to reset values");
        wait_cycles(3);
        sys_rst_n = 1'b1;
        wait_for_outputs(seg_pattern(0), 4'b0001, 4, "the digit enable after the second reset");
        wait_cycles(400);                       // 03:20 worth across more minute carries

        if (!saw_full_wrap)
        begin
            error_count = error_count + 1;
            $display("the run never reached the 59:59 to 00:00 wrap");
        end
        if (en_seen !== '1)
        begin
            error_count = error_count + 1;
            $display("not every digit position was enabled, seen %b", en_seen);
        end
        report_and_finish();
    end

endmodule

`default_nettype wire

// File: filelist.f
logic/clock_pkg.sv
logic/tick_divider.sv
logic/sexagesimal_counter.sv
logic/digit_scan.sv
logic/clock_display_top.sv
verif/clock_display_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the clock display testbench with Verilator
# exits nonzero when the log holds the fail message

LOG=sim.log

rm -rf obj_dir \
    && verilator --binary --timing --assert -f filelist.f \
        --top-module clock_display_tb -o clock_display_sim \
    && ./obj_dir/clock_display_sim > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat "$LOG"
grep -q "Regression failed" "$LOG" && { echo "simulation reported failure"; exit 1; }
grep -q "Regression passed" "$LOG" || { echo "no result line found in $LOG"; exit 1; }
echo "simulation passed"
